// ==== rcn_consts.svh ====
// rcn ring bus constants
// field widths, bridge windows, id ranges and register file size

`ifndef RCN_CONSTS_SVH
`define RCN_CONSTS_SVH

// packet field widths
`define RCN_PKT_W           67
`define RCN_ID_W            6
`define RCN_SEQ_W           2
`define RCN_MASK_W          4
`define RCN_ADDR_W          20
`define RCN_DATA_W          32

// id of the single bus master
`define RCN_MASTER_ID       6'h01

// ids owned by the sub ring
`define RCN_SUB_ID_MASK     6'h30
`define RCN_SUB_ID_BASE     6'h20

// byte address window of the sub ring, bits 21:2 are compared
`define RCN_SUB_ADDR_MASK   32'h0030_0000
`define RCN_SUB_ADDR_BASE   32'h0010_0000

// register slave bases (byte addresses)
`define RCN_MAIN_REGS_BASE  32'h0000_0000
`define RCN_SUB_REGS_BASE   32'h0010_0000
`define RCN_REGS_WORDS      16

`endif

// ==== rcn_pkg.sv ====
// rcn ring bus packet format
// one packet travels on each ring segment every cycle

`include "rcn_consts.svh"

package rcn_pkg;

    // ############################################################
    // ring packet, msb first as on the wire
    // ############################################################

    // valid   slot holds a packet
    // pending set on requests, cleared by the slave on the response
    // wr      write request
    // id      id of the requesting master
    // seq     request sequence number of that master
    // mask    byte enables for writes
    // addr    word address, byte address bits 21:2
    // data    write data on requests, read data on read responses
    typedef struct packed {
        logic                     valid;
        logic                     pending;
        logic                     wr;
        logic [`RCN_ID_W-1:0]     id;
        logic [`RCN_SEQ_W-1:0]    seq;
        logic [`RCN_MASK_W-1:0]   mask;
        logic [`RCN_ADDR_W-1:0]   addr;
        logic [`RCN_DATA_W-1:0]   data;
    } rcn_pkt_t;

endpackage

// ==== rcn_node_pkg.sv ====
// rcn node types
// client side operations and master node states

package rcn_node_pkg;

    // client operation on the request ports
    typedef enum logic [0:0] {
        RCN_OP_RD = 1'b0,
        RCN_OP_WR = 1'b1
    } rcn_op_e;

    // master node FSM
    typedef enum logic [1:0] {
        MST_IDLE      = 2'd0,
        MST_WAIT_SLOT = 2'd1,
        MST_WAIT_RSP  = 2'd2
    } rcn_master_state_e;

endpackage

// ==== rcn_reg_if.sv ====
// link between a ring slave node and its register file
// write strobe with byte mask, combinational read data

`timescale 1ns/1ps

`include "rcn_consts.svh"

interface rcn_reg_if;

    logic                                  wr_en;
    logic [`RCN_MASK_W-1:0]                wr_mask;
    logic [`RCN_DATA_W-1:0]                wr_data;
    // word offset inside the register file
    logic [$clog2(`RCN_REGS_WORDS)-1:0]    addr;
    logic [`RCN_DATA_W-1:0]                rd_data;

    modport node (
        output wr_en, wr_mask, wr_data, addr,
        input  rd_data
    );

    modport regs (
        input  wr_en, wr_mask, wr_data, addr,
        output rd_data
    );

endinterface

// ==== rcn_regs.sv ====
// rcn register file
// 16 words with byte-masked writes and combinational reads

`timescale 1ns/1ps

`include "rcn_consts.svh"

module rcn_regs (
    input  logic    clk,
    input  logic    rst,
    rcn_reg_if.regs regs
);

    localparam int BYTES = `RCN_DATA_W / 8;

    logic [`RCN_DATA_W-1:0] mem [`RCN_REGS_WORDS];

    // ############################################################
    // storage
    // ############################################################

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            for (int i = 0; i < `RCN_REGS_WORDS; i++)
                mem[i] <= '0;
        end
        else if (regs.wr_en)
        begin
            // only enabled byte lanes change
            for (int b = 0; b < BYTES; b++)
            begin
                if (regs.wr_mask[b])
                    mem[regs.addr][b*8 +: 8] <= regs.wr_data[b*8 +: 8];
            end
        end
    end

    // read port follows the address in the same cycle
    assign regs.rd_data = mem[regs.addr];

endmodule

// ==== rcn_slave.sv ====
// rcn register slave node
// answers requests inside its 16-word window from the attached register file,
// everything else passes on one cycle later

`timescale 1ns/1ps

`include "rcn_consts.svh"

module rcn_slave #(
    // byte base address of the register window
    parameter logic [31:0] BASE = 32'h0
) (
    input  logic              clk,
    input  logic              rst,
    input  rcn_pkg::rcn_pkt_t ring_in,
    output rcn_pkg::rcn_pkt_t ring_out,
    rcn_reg_if.node           regs
);

    localparam int OFS_W = $clog2(`RCN_REGS_WORDS);

    logic hit;

    // word address above the offset bits selects this slave
    assign hit = ring_in.valid && ring_in.pending &&
                 (ring_in.addr[`RCN_ADDR_W-1:OFS_W] == BASE[`RCN_ADDR_W+1:OFS_W+2]);

    // ############################################################
    // register file access
    // ############################################################

    assign regs.addr    = ring_in.addr[OFS_W-1:0];
    assign regs.wr_en   = hit && ring_in.wr;
    assign regs.wr_mask = ring_in.mask;
    assign regs.wr_data = ring_in.data;

    // ############################################################
    // ring output register
    // ############################################################

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            ring_out <= '0;
        end
        else
        begin
            ring_out <= ring_in;
            if (hit)
            begin
                // turn the request into its response in place
                ring_out.pending <= 1'b0;
                if (!ring_in.wr)
                    ring_out.data <= regs.rd_data;
            end
        end
    end

endmodule

// ==== rcn_master.sv ====
// rcn master node
// takes one client request at a time, inserts it into a free ring slot
// and removes the matching response from the ring

`timescale 1ns/1ps

`include "rcn_consts.svh"

module rcn_master #(
    parameter logic [`RCN_ID_W-1:0] MASTER_ID = `RCN_MASTER_ID
) (
    input  logic                    clk,
    input  logic                    rst,
    input  rcn_pkg::rcn_pkt_t       ring_in,
    output rcn_pkg::rcn_pkt_t       ring_out,
    input  logic                    req,
    input  rcn_node_pkg::rcn_op_e   op,
    // word address, byte address bits 21:2
    input  logic [`RCN_ADDR_W-1:0]  addr,
    input  logic [`RCN_MASK_W-1:0]  mask,
    input  logic [`RCN_DATA_W-1:0]  wdata,
    output logic                    busy,
    output logic                    rsp_valid,
    output logic [`RCN_DATA_W-1:0]  rsp_data
);

    rcn_node_pkg::rcn_master_state_e state;
    logic [`RCN_SEQ_W-1:0]           seq;
    rcn_node_pkg::rcn_op_e           req_op;
    logic [`RCN_ADDR_W-1:0]          req_addr;
    logic [`RCN_MASK_W-1:0]          req_mask;
    logic [`RCN_DATA_W-1:0]          req_wdata;
    rcn_pkg::rcn_pkt_t               req_pkt;
    logic                            accept;
    logic                            rsp_hit;

    assign accept  = req && (state == rcn_node_pkg::MST_IDLE);
    assign rsp_hit = (state == rcn_node_pkg::MST_WAIT_RSP) && ring_in.valid &&
                     !ring_in.pending && (ring_in.id == MASTER_ID) && (ring_in.seq == seq);

    always_comb
    begin
        req_pkt.valid   = 1'b1;
        req_pkt.pending = 1'b1;
        req_pkt.wr      = (req_op == rcn_node_pkg::RCN_OP_WR);
        req_pkt.id      = MASTER_ID;
        req_pkt.seq     = seq;
        req_pkt.mask    = req_mask;
        req_pkt.addr    = req_addr;
        req_pkt.data    = req_wdata;
    end

    // request payload is held until the response returns
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            req_op    <= op;
            req_addr  <= addr;
            req_mask  <= mask;
            req_wdata <= wdata;
        end
        if (rsp_hit)
            rsp_data <= ring_in.data;
    end

    // ############################################################
    // request FSM and ring slot
    // ############################################################

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state     <= rcn_node_pkg::MST_IDLE;
            seq       <= '0;
            rsp_valid <= 1'b0;
            ring_out  <= '0;
        end
        else
        begin
            rsp_valid <= 1'b0;
            ring_out  <= ring_in;
            case (state)
                rcn_node_pkg::MST_IDLE:
                    if (accept)
                    begin
                        seq   <= seq + `RCN_SEQ_W'(1);
                        state <= rcn_node_pkg::MST_WAIT_SLOT;
                    end
                rcn_node_pkg::MST_WAIT_SLOT:
                    // only an empty slot may carry the new request
                    if (!ring_in.valid)
                    begin
                        ring_out <= req_pkt;
                        state    <= rcn_node_pkg::MST_WAIT_RSP;
                    end
                rcn_node_pkg::MST_WAIT_RSP:
                    if (rsp_hit)
                    begin
                        ring_out.valid <= 1'b0;
                        rsp_valid      <= 1'b1;
                        state          <= rcn_node_pkg::MST_IDLE;
                    end
                default:
                    state <= rcn_node_pkg::MST_IDLE;
            endcase
        end
    end

    assign busy = (state != rcn_node_pkg::MST_IDLE);

endmodule

// ==== rcn_bridge.sv ====
// rcn ring bridge
// joins the main ring and the sub ring, requests cross by address window,
// responses cross by id range, two cycles per crossing

`timescale 1ns/1ps

`include "rcn_consts.svh"

module rcn_bridge #(
    parameter logic [`RCN_ID_W-1:0] ID_MASK   = '0,
    parameter logic [`RCN_ID_W-1:0] ID_BASE   = '0,
    parameter logic [31:0]          ADDR_MASK = '0,
    parameter logic [31:0]          ADDR_BASE = '0
) (
    input  logic              clk,
    input  logic              rst,
    input  rcn_pkg::rcn_pkt_t main_in,
    output rcn_pkg::rcn_pkt_t main_out,
    input  rcn_pkg::rcn_pkt_t sub_in,
    output rcn_pkg::rcn_pkt_t sub_out
);

    rcn_pkg::rcn_pkt_t main_rin;
    rcn_pkg::rcn_pkt_t main_rout;
    rcn_pkg::rcn_pkt_t sub_rin;
    rcn_pkg::rcn_pkt_t sub_rout;

    logic main_req;
    logic main_rsp;
    logic main_id_hit;
    logic main_addr_hit;
    logic sub_req;
    logic sub_rsp;
    logic sub_id_hit;
    logic sub_addr_hit;
    logic main_stay;
    logic sub_stay;
    logic swap;

    // ############################################################
    // packet classification
    // ############################################################

    assign main_req      = main_rin.valid && main_rin.pending;
    assign main_rsp      = main_rin.valid && !main_rin.pending;
    assign main_id_hit   = (main_rin.id & ID_MASK) == ID_BASE;
    assign main_addr_hit = (main_rin.addr & ADDR_MASK[`RCN_ADDR_W+1:2])
                           == ADDR_BASE[`RCN_ADDR_W+1:2];

    assign sub_req       = sub_rin.valid && sub_rin.pending;
    assign sub_rsp       = sub_rin.valid && !sub_rin.pending;
    assign sub_id_hit    = (sub_rin.id & ID_MASK) == ID_BASE;
    assign sub_addr_hit  = (sub_rin.addr & ADDR_MASK[`RCN_ADDR_W+1:2])
                           == ADDR_BASE[`RCN_ADDR_W+1:2];

    // traffic that belongs on its own ring
    assign main_stay = (main_req && !main_addr_hit) || (main_rsp && !main_id_hit);
    assign sub_stay  = (sub_req && sub_addr_hit) || (sub_rsp && sub_id_hit);

    // with nothing held on either side, every slot is empty or crossing,
    // so exchanging both slots moves the crossing packets without loss
    assign swap = !main_stay && !sub_stay;

    // ############################################################
    // input and output registers
    // ############################################################

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            main_rin  <= '0;
            main_rout <= '0;
            sub_rin   <= '0;
            sub_rout  <= '0;
        end
        else
        begin
            main_rin <= main_in;
            sub_rin  <= sub_in;
            if (swap)
            begin
                main_rout <= sub_rin;
                sub_rout  <= main_rin;
            end
            else
            begin
                // a blocked crossing packet goes round its ring again
                main_rout <= main_rin;
                sub_rout  <= sub_rin;
            end
        end
    end

    assign main_out = main_rout;
    assign sub_out  = sub_rout;

endmodule

// ==== rcn_subsys.sv ====
// rcn ring subsystem top level
// main ring: master, main register slave, bridge main side
// sub ring: bridge sub side, sub register slave

`timescale 1ns/1ps

`include "rcn_consts.svh"

module rcn_subsys (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    req,
    input  rcn_node_pkg::rcn_op_e   op,
    input  logic [`RCN_ADDR_W-1:0]  addr,
    input  logic [`RCN_MASK_W-1:0]  mask,
    input  logic [`RCN_DATA_W-1:0]  wdata,
    output logic                    busy,
    output logic                    rsp_valid,
    output logic [`RCN_DATA_W-1:0]  rsp_data
);

    // ring segments, named source to sink
    rcn_pkg::rcn_pkt_t main_mst_to_slv;
    rcn_pkg::rcn_pkt_t main_slv_to_brg;
    rcn_pkg::rcn_pkt_t main_brg_to_mst;
    rcn_pkg::rcn_pkt_t sub_brg_to_slv;
    rcn_pkg::rcn_pkt_t sub_slv_to_brg;

    rcn_reg_if main_regs_if ();
    rcn_reg_if sub_regs_if ();

    // ############################################################
    // main ring
    // ############################################################

    rcn_master #(
        .MASTER_ID (`RCN_MASTER_ID)
    ) i_master (
        .clk       (clk),
        .rst       (rst),
        .ring_in   (main_brg_to_mst),
        .ring_out  (main_mst_to_slv),
        .req       (req),
        .op        (op),
        .addr      (addr),
        .mask      (mask),
        .wdata     (wdata),
        .busy      (busy),
        .rsp_valid (rsp_valid),
        .rsp_data  (rsp_data)
    );

    rcn_slave #(.BASE(`RCN_MAIN_REGS_BASE)) i_main_slave (
        .clk      (clk),
        .rst      (rst),
        .ring_in  (main_mst_to_slv),
        .ring_out (main_slv_to_brg),
        .regs     (main_regs_if.node)
    );

    rcn_regs i_main_regs (
        .clk  (clk),
        .rst  (rst),
        .regs (main_regs_if.regs)
    );

    rcn_bridge #(
        .ID_MASK   (`RCN_SUB_ID_MASK),
        .ID_BASE   (`RCN_SUB_ID_BASE),
        .ADDR_MASK (`RCN_SUB_ADDR_MASK),
        .ADDR_BASE (`RCN_SUB_ADDR_BASE)
    ) i_bridge (
        .clk      (clk),
        .rst      (rst),
        .main_in  (main_slv_to_brg),
        .main_out (main_brg_to_mst),
        .sub_in   (sub_slv_to_brg),
        .sub_out  (sub_brg_to_slv)
    );

    // ############################################################
    // sub ring
    // ############################################################

    rcn_slave #(.BASE(`RCN_SUB_REGS_BASE)) i_sub_slave (
        .clk      (clk),
        .rst      (rst),
        .ring_in  (sub_brg_to_slv),
        .ring_out (sub_slv_to_brg),
        .regs     (sub_regs_if.node)
    );

    rcn_regs i_sub_regs (
        .clk  (clk),
        .rst  (rst),
        .regs (sub_regs_if.regs)
    );

endmodule

// ==== tb_rcn_subsys.sv ====
// testbench for the rcn ring subsystem
// directed reads and writes to both register slaves, checked against
// a byte-masked reference model of both register files

`timescale 1ns/1ps

`include "rcn_consts.svh"

module tb_rcn_subsys;

    localparam int CLK_PERIOD  = 4;
    localparam int TXN_CYCLES  = 64;
    localparam int RAND_ROUNDS = 24;
    // two full-mask passes 64, request cut by reset 1, reset reads 32,
    // random 48, same offset 16, busy 3
    localparam int N_TXN       = 164;
    localparam int WATCHDOG_NS = (N_TXN * TXN_CYCLES + 100) * CLK_PERIOD;

    logic                    clk = 1'b0;
    logic                    rst;
    logic                    req;
    rcn_node_pkg::rcn_op_e   op;
    logic [`RCN_ADDR_W-1:0]  addr;
    logic [`RCN_MASK_W-1:0]  mask;
    logic [`RCN_DATA_W-1:0]  wdata;
    logic                    busy;
    logic                    rsp_valid;
    logic [`RCN_DATA_W-1:0]  rsp_data;

    logic [31:0] lfsr_state = 32'h803b7519;
    logic [31:0] main_model [`RCN_REGS_WORDS];
    logic [31:0] sub_model [`RCN_REGS_WORDS];
    int          checks = 0;
    int          mismatches = 0;
    int          timeouts = 0;

    rcn_subsys i_rcn_subsys (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .op        (op),
        .addr      (addr),
        .mask      (mask),
        .wdata     (wdata),
        .busy      (busy),
        .rsp_valid (rsp_valid),
        .rsp_data  (rsp_data)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ############################################################
    // stimulus helpers and reference model
    // ############################################################

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        int          i;
        v = '0;
        for (i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // word address of a register over byte address bits 21:2
    function automatic logic [19:0] word_addr(input logic sub, input logic [3:0] ofs);
        logic [31:0] base;
        base = sub ? `RCN_SUB_REGS_BASE : `RCN_MAIN_REGS_BASE;
        return base[21:2] | {16'h0, ofs};
    endfunction

    function automatic logic [31:0] model_read(input logic sub, input logic [3:0] ofs);
        if (sub)
            return sub_model[ofs];
        return main_model[ofs];
    endfunction

    function automatic void model_write(input logic sub, input logic [3:0] ofs,
                                        input logic [3:0] m, input logic [31:0] d);
        logic [31:0] v;
        int          b;
        v = model_read(sub, ofs);
        for (b = 0; b < 4; b++)
        begin
            if (m[b])
                v[b*8 +: 8] = d[b*8 +: 8];
        end
        if (sub)
            sub_model[ofs] = v;
        else
            main_model[ofs] = v;
    endfunction

    task automatic clear_model();
        int i;
        for (i = 0; i < `RCN_REGS_WORDS; i++)
        begin
            main_model[i] = '0;
            sub_model[i]  = '0;
        end
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp)
        else
        begin
            mismatches++;
            $display("Fail at time %0t: %s got %08h expected %08h", $time, what, got, exp);
        end
    endtask

    // ############################################################
    // client transactions
    // ############################################################

    // one request that returns once rsp_valid is seen or the bound runs out
    task automatic issue_request(input rcn_node_pkg::rcn_op_e o, input logic [19:0] a,
                                 input logic [3:0] m, input logic [31:0] d,
                                 output logic [31:0] rdata, output logic ok);
        int n;
        n  = 0;
        ok = 1'b0;
        @(posedge clk);
        req   <= 1'b1;
        op    <= o;
        addr  <= a;
        mask  <= m;
        wdata <= d;
        @(posedge clk);
        req <= 1'b0;
        while (!ok && n < TXN_CYCLES)
        begin
            @(negedge clk);
            n++;
            if (rsp_valid)
                ok = 1'b1;
        end
        rdata = rsp_data;
        if (!ok)
        begin
            timeouts++;
            $display("Error at time %0t: no response within %0d cycles for word address %05h",
                     $time, TXN_CYCLES, a);
        end
        else
            check_value("busy in the response cycle", {31'b0, busy}, 32'h0);
    endtask

    task automatic write_word(input logic sub, input logic [3:0] ofs,
                              input logic [3:0] m, input logic [31:0] d);
        logic [31:0] rd;
        logic        ok;
        issue_request(rcn_node_pkg::RCN_OP_WR, word_addr(sub, ofs), m, d, rd, ok);
        if (ok)
            model_write(sub, ofs, m, d);
    endtask

    task automatic read_and_check(input logic sub, input logic [3:0] ofs);
        logic [31:0] rd;
        logic        ok;
        issue_request(rcn_node_pkg::RCN_OP_RD, word_addr(sub, ofs), 4'hf, 32'h0, rd, ok);
        if (ok)
            check_value($sformatf("read of %s slave word %0d", sub ? "sub" : "main", ofs),
                        rd, model_read(sub, ofs));
    endtask

    // ############################################################
    // tests
    // ############################################################

    // reset lands while a sub slave write is still on the ring
    task automatic reset_during_request();
        @(posedge clk);
        req   <= 1'b1;
        op    <= rcn_node_pkg::RCN_OP_WR;
        addr  <= word_addr(1'b1, 4'd3);
        mask  <= 4'hf;
        wdata <= rand_bits(32);
        @(posedge clk);
        req <= 1'b0;
        @(negedge clk);
        check_value("busy before the second reset", {31'b0, busy}, 32'h1);
        @(posedge clk);
        rst <= 1'b1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        clear_model();
    endtask

    task automatic reset_state_reads();
        int i;
        @(negedge clk);
        check_value("busy after reset", {31'b0, busy}, 32'h0);
        check_value("rsp_valid after reset", {31'b0, rsp_valid}, 32'h0);
        for (i = 0; i < `RCN_REGS_WORDS; i++)
        begin
            read_and_check(1'b0, i[3:0]);
            read_and_check(1'b1, i[3:0]);
        end
    endtask

    // sub slave traffic crosses the bridge both ways
    task automatic full_mask_rw(input logic sub);
        int i;
        for (i = 0; i < `RCN_REGS_WORDS; i++)
            write_word(sub, i[3:0], 4'hf, rand_bits(32));
        for (i = 0; i < `RCN_REGS_WORDS; i++)
            read_and_check(sub, i[3:0]);
    endtask

    task automatic masked_random_rw();
        logic [31:0] r;
        logic        sub;
        logic [3:0]  ofs;
        logic [3:0]  m;
        logic [31:0] d;
        int          i;
        for (i = 0; i < RAND_ROUNDS; i++)
        begin
            r   = rand_bits(1);
            sub = r[0];
            r   = rand_bits(4);
            ofs = r[3:0];
            r   = rand_bits(4);
            m   = r[3:0];
            d   = rand_bits(32);
            write_word(sub, ofs, m, d);
            read_and_check(sub, ofs);
        end
    endtask

    task automatic same_offset_both_slaves();
        logic [3:0]  offsets [4];
        logic [31:0] d_main;
        logic [31:0] d_sub;
        int          i;
        offsets = '{4'd0, 4'd7, 4'd9, 4'd15};
        for (i = 0; i < 4; i++)
        begin
            d_main = rand_bits(32);
            d_sub  = rand_bits(32);
            if (d_sub == d_main)
                d_sub = ~d_main;
            write_word(1'b0, offsets[i], 4'hf, d_main);
            write_word(1'b1, offsets[i], 4'hf, d_sub);
            read_and_check(1'b0, offsets[i]);
            read_and_check(1'b1, offsets[i]);
        end
    endtask

    // a second req while busy must leave no trace
    task automatic busy_request_ignored();
        logic [31:0] first_data;
        logic [19:0] a;
        int          pulses;
        int          n;
        first_data = rand_bits(32);
        a          = word_addr(1'b0, 4'd5);
        pulses     = 0;
        @(posedge clk);
        req   <= 1'b1;
        op    <= rcn_node_pkg::RCN_OP_WR;
        addr  <= a;
        mask  <= 4'hf;
        wdata <= first_data;
        @(posedge clk);
        req <= 1'b0;
        @(negedge clk);
        if (rsp_valid)
            pulses++;
        check_value("busy after accepted request", {31'b0, busy}, 32'h1);
        @(posedge clk);
        req   <= 1'b1;
        wdata <= ~first_data;
        @(negedge clk);
        if (rsp_valid)
            pulses++;
        check_value("busy while extra request is pulsed", {31'b0, busy}, 32'h1);
        @(posedge clk);
        req <= 1'b0;
        for (n = 0; n < TXN_CYCLES; n++)
        begin
            @(negedge clk);
            if (rsp_valid)
                pulses++;
        end
        check_value("rsp_valid pulses for one accepted request", 32'(pulses), 32'd1);
        model_write(1'b0, 4'd5, 4'hf, first_data);
        read_and_check(1'b0, 4'd5);
    endtask

    // ############################################################
    // run control
    // ############################################################

    initial
    begin
        rst   <= 1'b1;
        req   <= 1'b0;
        op    <= rcn_node_pkg::RCN_OP_RD;
        addr  <= '0;
        mask  <= '0;
        wdata <= '0;
        clear_model();
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        full_mask_rw(1'b0);
        full_mask_rw(1'b1);
        reset_during_request();
        reset_state_reads();
        masked_random_rw();
        same_offset_both_slaves();
        busy_request_ignored();

        $display("checks %0d, value mismatches %0d, timeouts %0d",
                 checks, mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("Error: watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+.
rcn_pkg.sv
rcn_node_pkg.sv
rcn_reg_if.sv
rcn_regs.sv
rcn_slave.sv
rcn_master.sv
rcn_bridge.sv
rcn_subsys.sv
tb_rcn_subsys.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile and run the rcn subsystem testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -f build.f --top-module tb_rcn_subsys \
    -Mdir "$BUILD_DIR" -o sim_tb
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

"./$BUILD_DIR/sim_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TESTBENCH FAILED" "$LOG"; then
    exit 1
fi
if ! grep -q "TESTBENCH PASSED" "$LOG"; then
    echo "simulation ended without a result line"
    exit 1
fi
exit 0
